// ==== Makefile ====
# Verilator build and run of the host command bridge testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build folder"

test:
	verilator --binary --timing --top-module tb_hps_bridge -Mdir build -f compile.f
	out="$$(./build/Vtb_hps_bridge)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf build

// ==== compile.f ====
+incdir+verif
rtl/hps_pkg.sv
rtl/word_bus_if.sv
rtl/joy_status_regs.sv
rtl/key_event.sv
rtl/file_loader.sv
rtl/host_cmd_ctrl.sv
rtl/hps_bridge.sv
verif/tb_hps_bridge.sv

// ==== rtl/file_loader.sv ====
// file download
// index, start and stop, address counting and the valid/ready output

`timescale 1ns/100ps

module file_loader #(
	parameter int WIDE = 0
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_ready,
	word_bus_if.sink    bus,
	output logic        ioctl_download,
	output logic [7:0]  ioctl_index,
	output logic        ioctl_valid,
	output logic [26:0] ioctl_addr,
	output logic [15:0] ioctl_data,
	output logic        word_ready
);

	// 16-bit words cover two byte addresses
	localparam logic [26:0] ADDR_STEP = (WIDE != 0) ? 27'd2 : 27'd1;

	logic [26:0] addr;
	logic        dat_hit;

	assign dat_hit = bus.word_valid && bus.cmd == hps_pkg::CMD_FILE_TX_DAT;

	// host is held off while a word waits on the output
	assign word_ready = ~ioctl_valid;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_valid    <= 1'b0;
			ioctl_addr     <= '0;
			addr           <= '0;
		end else begin
			if (ioctl_valid && ioctl_ready) begin
				ioctl_valid <= 1'b0;
			end

			if (bus.word_valid && bus.cmd == hps_pkg::CMD_FILE_INDEX) begin
				ioctl_index <= bus.din[7:0];
			end

			if (bus.word_valid && bus.cmd == hps_pkg::CMD_FILE_TX) begin
				if (bus.din[7:0] != 8'h00) begin
					addr           <= '0;
					ioctl_download <= 1'b1;
				end else begin
					ioctl_download <= 1'b0;
				end
			end

			if (dat_hit) begin
				ioctl_addr  <= addr;
				ioctl_valid <= 1'b1;
				addr        <= addr + ADDR_STEP;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dat_hit) begin
			ioctl_data <= (WIDE != 0) ? bus.din : {8'h00, bus.din[7:0]};
		end
	end

endmodule

// ==== rtl/host_cmd_ctrl.sv ====
// host frame controller
// command capture, word index, ready gating and the registered reply
// including the configuration string readback

`timescale 1ns/100ps

module host_cmd_ctrl #(
	parameter int STRLEN = 1
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       host_frame,
	input  logic                       host_valid,
	input  logic [hps_pkg::WORD_W-1:0] host_din,
	input  logic [8*STRLEN-1:0]        conf_str,
	input  logic [hps_pkg::WORD_W-1:0] req_reply,
	input  logic                       word_ready,
	output logic                       host_ready,
	output logic [hps_pkg::WORD_W-1:0] host_dout,
	word_bus_if.ctrl                   bus
);

	logic                       accept;
	logic                       has_cmd;
	logic [hps_pkg::WORD_W-1:0] cmd_q;
	logic [hps_pkg::WORD_W-1:0] cmd_sel;
	logic [hps_pkg::IDX_W-1:0]  idx_q;
	logic                       frame_d;
	logic [hps_pkg::WORD_W-1:0] dout_q;
	logic [7:0]                 conf_byte;
	logic [hps_pkg::WORD_W-1:0] reply;

	assign host_ready = word_ready;
	assign accept     = host_frame & host_valid & host_ready;

	// before the command is latched the incoming word is the command
	assign cmd_sel = has_cmd ? cmd_q : host_din;

	////////////////////
	// word bus
	////////////////////

	assign bus.word_valid = accept & has_cmd;
	assign bus.cmd_valid  = accept & ~has_cmd;
	assign bus.cmd        = cmd_sel;
	assign bus.word_idx   = idx_q;
	assign bus.din        = host_din;
	assign bus.frame_end  = frame_d & ~host_frame;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			has_cmd <= 1'b0;
			cmd_q   <= '0;
			idx_q   <= '0;
			frame_d <= 1'b0;
			dout_q  <= '0;
		end else begin
			frame_d <= host_frame;
			if (!host_frame) begin
				has_cmd <= 1'b0;
				idx_q   <= '0;
				dout_q  <= '0;
			end else if (accept) begin
				if (!has_cmd) begin
					cmd_q <= host_din;
				end
				has_cmd <= 1'b1;
				idx_q   <= idx_q + 1'b1;
				dout_q  <= reply;
			end
		end
	end

	////////////////////
	// reply select
	////////////////////

	// word n returns byte n-1 counted from the top of the string
	always_comb begin
		conf_byte = '0;
		if (idx_q != '0 && int'(idx_q) <= STRLEN) begin
			conf_byte = conf_str[8 * (STRLEN - int'(idx_q)) +: 8];
		end
	end

	always_comb begin
		reply = '0;
		if (cmd_sel == hps_pkg::CMD_STATUS_REQ) begin
			reply = req_reply;
		end else if (cmd_sel == hps_pkg::CMD_CONF_STR) begin
			reply = {8'h00, conf_byte};
		end
	end

	// nothing is driven to the host outside a frame
	assign host_dout = host_frame ? dout_q : '0;

endmodule

// ==== rtl/hps_bridge.sv ====
// host command bridge top level
// plain host and core ports around the controller and datapath blocks

`timescale 1ns/100ps

module hps_bridge #(
	parameter int STRLEN = 1,
	parameter int WIDE   = 0
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       host_frame,
	input  logic                       host_valid,
	output logic                       host_ready,
	input  logic [hps_pkg::WORD_W-1:0] host_din,
	output logic [hps_pkg::WORD_W-1:0] host_dout,
	input  logic [8*STRLEN-1:0]        conf_str,
	output logic [1:0]                 buttons,
	output logic                       forced_scandoubler,
	output logic [31:0]                joystick_0,
	output logic [31:0]                joystick_1,
	output logic [31:0]                joystick_2,
	output logic [31:0]                joystick_3,
	output logic [63:0]                status,
	input  logic [63:0]                status_in,
	input  logic                       status_set,
	output logic [10:0]                ps2_key,
	output logic                       ioctl_download,
	output logic [7:0]                 ioctl_index,
	output logic                       ioctl_valid,
	input  logic                       ioctl_ready,
	output logic [26:0]                ioctl_addr,
	output logic [15:0]                ioctl_data
);

	logic [hps_pkg::WORD_W-1:0] req_reply;
	logic                       word_ready;

	word_bus_if bus ();

	host_cmd_ctrl #(
		.STRLEN (STRLEN)
	) i_host_cmd_ctrl (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.host_frame (host_frame),
		.host_valid (host_valid),
		.host_din   (host_din),
		.conf_str   (conf_str),
		.req_reply  (req_reply),
		.word_ready (word_ready),
		.host_ready (host_ready),
		.host_dout  (host_dout),
		.bus        (bus.ctrl)
	);

	joy_status_regs i_joy_status_regs (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.status_in          (status_in),
		.status_set         (status_set),
		.bus                (bus.sink),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.status             (status),
		.req_reply          (req_reply)
	);

	key_event i_key_event (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus.sink),
		.ps2_key (ps2_key)
	);

	// upper data byte stays zero in 8-bit mode
	file_loader #(
		.WIDE (WIDE)
	) i_file_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_ready    (ioctl_ready),
		.bus            (bus.sink),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_valid    (ioctl_valid),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.word_ready     (word_ready)
	);

endmodule

// ==== rtl/hps_pkg.sv ====
// shared definitions for the host command bridge
// word widths, command codes and keyboard special sequences

package hps_pkg;

	////////////////////
	// widths
	////////////////////

	localparam int WORD_W = 16;
	localparam int IDX_W  = 10;

	////////////////////
	// command codes
	////////////////////

	localparam logic [WORD_W-1:0] CMD_CFG         = 16'h0001;
	localparam logic [WORD_W-1:0] CMD_JOY0        = 16'h0002;
	localparam logic [WORD_W-1:0] CMD_JOY1        = 16'h0003;
	localparam logic [WORD_W-1:0] CMD_KBD         = 16'h0005;
	localparam logic [WORD_W-1:0] CMD_JOY2        = 16'h0010;
	localparam logic [WORD_W-1:0] CMD_JOY3        = 16'h0011;
	localparam logic [WORD_W-1:0] CMD_CONF_STR    = 16'h0014;
	localparam logic [WORD_W-1:0] CMD_STATUS      = 16'h001E;
	localparam logic [WORD_W-1:0] CMD_STATUS_REQ  = 16'h0029;
	localparam logic [WORD_W-1:0] CMD_FILE_TX     = 16'h0053;
	localparam logic [WORD_W-1:0] CMD_FILE_TX_DAT = 16'h0054;
	localparam logic [WORD_W-1:0] CMD_FILE_INDEX  = 16'h0055;

	////////////////////
	// keyboard
	////////////////////

	// raw byte sequences with the oldest byte in the top
	localparam logic [31:0] KEY_PRNSCR_DN = 32'hE012E07C;
	localparam logic [31:0] KEY_PRNSCR_UP = 32'h7CE0F012;
	localparam logic [31:0] KEY_PAUSE_DN  = 32'hF014F077;

	// {pressed, extended, code} reported for them
	localparam logic [9:0] KEY_CODE_PRNSCR_DN = 10'h37C;
	localparam logic [9:0] KEY_CODE_PRNSCR_UP = 10'h17C;
	localparam logic [9:0] KEY_CODE_PAUSE_DN  = 10'h377;

	// upper nibble of the status request reply
	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;

endpackage

// ==== rtl/joy_status_regs.sv ====
// configuration byte, joystick and status registers
// status set request capture and its reply words

`timescale 1ns/100ps

module joy_status_regs (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic [63:0]                status_in,
	input  logic                       status_set,
	word_bus_if.sink                   bus,
	output logic [1:0]                 buttons,
	output logic                       forced_scandoubler,
	output logic [31:0]                joystick_0,
	output logic [31:0]                joystick_1,
	output logic [31:0]                joystick_2,
	output logic [31:0]                joystick_3,
	output logic [63:0]                status,
	output logic [hps_pkg::WORD_W-1:0] req_reply
);

	logic [7:0]  cfg;
	logic [31:0] joy [4];
	logic        joy_hit;
	logic [1:0]  joy_num;
	logic        set_d;
	logic [63:0] status_req;
	logic [3:0]  req_cnt;

	// bits 2, 3 and 5 of the config byte are handled outside the core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	assign joystick_0 = joy[0];
	assign joystick_1 = joy[1];
	assign joystick_2 = joy[2];
	assign joystick_3 = joy[3];

	always_comb begin
		joy_hit = 1'b1;
		joy_num = 2'd0;
		case (bus.cmd)
			hps_pkg::CMD_JOY0: joy_num = 2'd0;
			hps_pkg::CMD_JOY1: joy_num = 2'd1;
			hps_pkg::CMD_JOY2: joy_num = 2'd2;
			hps_pkg::CMD_JOY3: joy_num = 2'd3;
			default: joy_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg        <= '0;
			status     <= '0;
			set_d      <= 1'b0;
			status_req <= '0;
			req_cnt    <= '0;
			for (int i = 0; i < 4; i++) begin
				joy[i] <= '0;
			end
		end else begin
			// request capture on the rising edge of status_set
			set_d <= status_set;
			if (status_set && !set_d) begin
				status_req <= status_in;
				req_cnt    <= req_cnt + 1'b1;
			end

			if (bus.word_valid) begin
				if (bus.cmd == hps_pkg::CMD_CFG && bus.word_idx == 1) begin
					cfg <= bus.din[7:0];
				end
				if (joy_hit) begin
					if (bus.word_idx == 1) begin
						joy[joy_num][15:0] <= bus.din;
					end else if (bus.word_idx == 2) begin
						joy[joy_num][31:16] <= bus.din;
					end
				end
				if (bus.cmd == hps_pkg::CMD_STATUS) begin
					case (bus.word_idx)
						1: status[15:0]  <= bus.din;
						2: status[31:16] <= bus.din;
						3: status[47:32] <= bus.din;
						4: status[63:48] <= bus.din;
						default: ;
					endcase
				end
			end
		end
	end

	// command word gets tag and count, then four halves, low first
	always_comb begin
		req_reply = '0;
		if (bus.cmd == hps_pkg::CMD_STATUS_REQ) begin
			case (bus.word_idx)
				0: req_reply = {8'h00, hps_pkg::STATUS_REQ_TAG, req_cnt};
				1: req_reply = status_req[15:0];
				2: req_reply = status_req[31:16];
				3: req_reply = status_req[47:32];
				4: req_reply = status_req[63:48];
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/key_event.sv ====
// keyboard byte assembly
// key event with toggle, pressed and extended bits at frame end

`timescale 1ns/100ps

module key_event (
	input  logic        clk_sys,
	input  logic        reset,
	word_bus_if.sink    bus,
	output logic [10:0] ps2_key
);

	logic [31:0] raw;
	logic        kbd_active;
	logic        skip;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_code;

	// an F0 before the key byte marks a release
	assign pressed  = raw[15:8] != 8'hF0;
	assign extended = pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);

	always_comb begin
		key_code = {pressed, extended, raw[7:0]};
		if (raw == hps_pkg::KEY_PRNSCR_DN) begin
			key_code = hps_pkg::KEY_CODE_PRNSCR_DN;
		end else if (raw == hps_pkg::KEY_PRNSCR_UP) begin
			key_code = hps_pkg::KEY_CODE_PRNSCR_UP;
		end else if (raw == hps_pkg::KEY_PAUSE_DN) begin
			key_code = hps_pkg::KEY_CODE_PAUSE_DN;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			raw        <= '0;
			kbd_active <= 1'b0;
			skip       <= 1'b0;
			ps2_key    <= '0;
		end else begin
			if (bus.cmd_valid) begin
				kbd_active <= bus.cmd == hps_pkg::CMD_KBD;
				skip       <= 1'b0;
				if (bus.cmd == hps_pkg::CMD_KBD) begin
					raw <= '0;
				end
			end

			if (bus.word_valid && bus.cmd == hps_pkg::CMD_KBD) begin
				// high byte all ones drops the whole frame
				if (&bus.din[15:8]) begin
					skip <= 1'b1;
				end else if (!skip) begin
					raw <= {raw[23:0], bus.din[7:0]};
				end
			end

			if (bus.frame_end) begin
				if (kbd_active && !skip) begin
					ps2_key <= {~ps2_key[10], key_code};
				end
				kbd_active <= 1'b0;
				skip       <= 1'b0;
			end
		end
	end

endmodule

// ==== rtl/word_bus_if.sv ====
// accepted host word bus
// driven by the command controller, read by the datapath blocks

`timescale 1ns/100ps

interface word_bus_if;

	logic                         word_valid;
	logic                         cmd_valid;
	logic [hps_pkg::WORD_W-1:0]   cmd;
	logic [hps_pkg::IDX_W-1:0]    word_idx;
	logic [hps_pkg::WORD_W-1:0]   din;
	logic                         frame_end;

	modport ctrl (
		output word_valid, cmd_valid, cmd, word_idx, din, frame_end
	);

	modport sink (
		input word_valid, cmd_valid, cmd, word_idx, din, frame_end
	);

endinterface

// ==== verif/tb_hps_tasks.svh ====
// host word and frame tasks with random valid gaps
// register model updates and check helpers for the bridge testbench

task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_regs();
	check_value("buttons", 64'(buttons), 64'(m_cfg[1:0]));
	check_value("forced_scandoubler", 64'(forced_scandoubler), 64'(m_cfg[4]));
	check_value("joystick_0", 64'(joystick_0), 64'(m_joy[0]));
	check_value("joystick_1", 64'(joystick_1), 64'(m_joy[1]));
	check_value("joystick_2", 64'(joystick_2), 64'(m_joy[2]));
	check_value("joystick_3", 64'(joystick_3), 64'(m_joy[3]));
	check_value("status", status, m_status);
	check_value("ps2_key", 64'(ps2_key), 64'(m_key));
	check_value("ioctl_index", 64'(ioctl_index), 64'(m_index));
	check_value("ioctl_download", 64'(ioctl_download), 64'(m_download));
endtask

// one word is accepted on the edge after host_ready is seen high
task automatic send_word(input logic [15:0] w);
	int gap;
	gap = $urandom_range(0, 2);
	repeat (gap) begin
		@(posedge clk_sys);
		#2;
	end
	host_valid = 1'b1;
	host_din   = w;
	#1;
	while (!host_ready) begin
		@(posedge clk_sys);
		#3;
	end
	@(posedge clk_sys);
	#2;
	replies.push_back(host_dout);
	host_valid = 1'b0;
endtask

// command word then every word queued in tx_data
task automatic send_frame(input logic [15:0] cmd);
	replies.delete();
	host_frame = 1'b1;
	send_word(cmd);
	foreach (tx_data[i]) begin
		send_word(tx_data[i]);
	end
	host_frame = 1'b0;
	// reply must drop as soon as the frame is gone
	#1;
	check_value("host_dout outside a frame", 64'(host_dout), 64'd0);
	// frame end pulse plus one edge for the key event
	repeat (2) @(posedge clk_sys);
	#2;
endtask

function automatic void apply_reg_frame(input logic [15:0] cmd);
	int idx;
	for (int i = 0; i < tx_data.size(); i++) begin
		idx = i + 1;
		if (cmd == hps_pkg::CMD_CFG && idx == 1) begin
			m_cfg = tx_data[i][7:0];
		end
		if (cmd == hps_pkg::CMD_STATUS && idx <= 4) begin
			m_status[16*(idx-1) +: 16] = tx_data[i];
		end
		for (int j = 0; j < 4; j++) begin
			if (cmd == reg_cmd[j+1] && idx <= 2) begin
				m_joy[j][16*(idx-1) +: 16] = tx_data[i];
			end
		end
	end
endfunction

// {pressed, extended, key} for the bytes of one keyboard frame
function automatic logic [9:0] expected_key_code();
	logic [31:0] raw;
	logic        brk;
	logic        ext;
	logic [7:0]  key;
	raw = '0;
	brk = 1'b0;
	ext = 1'b0;
	key = '0;
	foreach (kbd_bytes[i]) begin
		raw = {raw[23:0], kbd_bytes[i]};
	end
	if (raw == hps_pkg::KEY_PRNSCR_DN) begin
		return hps_pkg::KEY_CODE_PRNSCR_DN;
	end
	if (raw == hps_pkg::KEY_PRNSCR_UP) begin
		return hps_pkg::KEY_CODE_PRNSCR_UP;
	end
	if (raw == hps_pkg::KEY_PAUSE_DN) begin
		return hps_pkg::KEY_CODE_PAUSE_DN;
	end
	foreach (kbd_bytes[i]) begin
		if (kbd_bytes[i] == 8'hE0) begin
			ext = 1'b1;
		end else if (kbd_bytes[i] == 8'hF0) begin
			brk = 1'b1;
		end else begin
			key = kbd_bytes[i];
		end
	end
	return {~brk, ext, key};
endfunction

// ==== verif/tb_hps_bridge.sv ====
// testbench for the host command bridge
// clock, reset, watchdog, download sink and the random test sequence

`timescale 1ns/100ps

module tb_hps_bridge;

	localparam int STRLEN = 6;
	localparam int N_REG  = 40;
	localparam int N_REQ  = 4;
	localparam int N_KBD  = 30;
	localparam int N_DAT  = 24;
	// register, string, request, keyboard and four download frames
	localparam int FRAMES = N_REG + 1 + N_REQ + N_KBD + 4;

	logic                clk_sys;
	logic                reset;
	logic                host_frame;
	logic                host_valid;
	logic                host_ready;
	logic [15:0]         host_din;
	logic [15:0]         host_dout;
	logic [8*STRLEN-1:0] conf_str;
	logic [1:0]          buttons;
	logic                forced_scandoubler;
	logic [31:0]         joystick_0;
	logic [31:0]         joystick_1;
	logic [31:0]         joystick_2;
	logic [31:0]         joystick_3;
	logic [63:0]         status;
	logic [63:0]         status_in;
	logic                status_set;
	logic [10:0]         ps2_key;
	logic                ioctl_download;
	logic [7:0]          ioctl_index;
	logic                ioctl_valid;
	logic                ioctl_ready;
	logic [26:0]         ioctl_addr;
	logic [15:0]         ioctl_data;

	int          checks;
	int          errors;
	logic [15:0] tx_data[$];
	logic [15:0] replies[$];
	logic [15:0] dat_words[$];
	logic [7:0]  kbd_bytes[$];
	logic [26:0] sink_addr[$];
	logic [15:0] sink_data[$];
	logic [15:0] reg_cmd [6];
	int          reg_len [6];
	logic [31:0] specials [3];
	logic [7:0]  conf_bytes [STRLEN];

	// model state
	logic [7:0]  m_cfg;
	logic [31:0] m_joy [4];
	logic [63:0] m_status;
	logic [10:0] m_key;
	logic [7:0]  m_index;
	logic        m_download;
	logic [63:0] m_req;
	logic [3:0]  m_req_cnt;

	`include "tb_hps_tasks.svh"

	hps_bridge #(
		.STRLEN (STRLEN),
		.WIDE   (1)
	) i_hps_bridge (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.host_frame         (host_frame),
		.host_valid         (host_valid),
		.host_ready         (host_ready),
		.host_din           (host_din),
		.host_dout          (host_dout),
		.conf_str           (conf_str),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_valid        (ioctl_valid),
		.ioctl_ready        (ioctl_ready),
		.ioctl_addr         (ioctl_addr),
		.ioctl_data         (ioctl_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#10 clk_sys = ~clk_sys;
		end
	end

	// download sink records a transfer half a cycle before its edge
	initial begin
		ioctl_ready = 1'b0;
		forever begin
			@(posedge clk_sys);
			#2;
			ioctl_ready = ($urandom_range(0, 2) != 0);
			@(negedge clk_sys);
			if (ioctl_valid && ioctl_ready) begin
				sink_addr.push_back(ioctl_addr);
				sink_data.push_back(ioctl_data);
			end
		end
	end

	initial begin
		repeat (200 * FRAMES) @(posedge clk_sys);
		$display("timeout after %0d cycles, the test sequence did not finish", 200 * FRAMES);
		$display("Test failures found");
		$finish;
	end

	initial begin
		logic [15:0] cmd;
		int          kind;
		int          n;
		int          gap;
		logic [31:0] seq;
		void'($urandom(32'hde061888));
		checks = 0;
		errors = 0;
		reg_cmd = '{hps_pkg::CMD_CFG, hps_pkg::CMD_JOY0, hps_pkg::CMD_JOY1,
			hps_pkg::CMD_JOY2, hps_pkg::CMD_JOY3, hps_pkg::CMD_STATUS};
		reg_len = '{1, 2, 2, 2, 2, 4};
		specials = '{hps_pkg::KEY_PRNSCR_DN, hps_pkg::KEY_PRNSCR_UP, hps_pkg::KEY_PAUSE_DN};
		// first string byte goes in the top of conf_str
		for (int i = 0; i < STRLEN; i++) begin
			conf_bytes[i] = 8'($urandom_range(32, 126));
			conf_str[8*(STRLEN-1-i) +: 8] = conf_bytes[i];
		end
		m_cfg      = '0;
		m_joy      = '{default: '0};
		m_status   = '0;
		m_key      = '0;
		m_index    = '0;
		m_download = 1'b0;
		m_req      = '0;
		m_req_cnt  = '0;
		reset      = 1'b1;
		host_frame = 1'b0;
		host_valid = 1'b0;
		host_din   = '0;
		status_in  = '0;
		status_set = 1'b0;
		repeat (4) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		check_regs();
		check_value("host_ready after reset", 64'(host_ready), 64'd1);
		check_value("ioctl_valid after reset", 64'(ioctl_valid), 64'd0);
		check_value("host_dout after reset", 64'(host_dout), 64'd0);

		////////////////////
		// register writes
		////////////////////
		repeat (N_REG) begin
			kind = $urandom_range(0, 5);
			cmd  = reg_cmd[kind];
			n    = $urandom_range(1, reg_len[kind]);
			tx_data.delete();
			repeat (n) begin
				tx_data.push_back(16'($urandom));
			end
			apply_reg_frame(cmd);
			send_frame(cmd);
			check_regs();
			foreach (replies[i]) begin
				check_value("reply to a write frame", 64'(replies[i]), 64'd0);
			end
		end

		// configuration string with two words past its end
		tx_data.delete();
		repeat (8) begin
			tx_data.push_back(16'h0000);
		end
		send_frame(hps_pkg::CMD_CONF_STR);
		check_value("string command reply", 64'(replies[0]), 64'd0);
		for (int i = 1; i <= 8; i++) begin
			check_value("string byte", 64'(replies[i]),
				(i <= STRLEN) ? 64'(conf_bytes[i-1]) : 64'd0);
		end

		////////////////////
		// status requests
		////////////////////
		repeat (N_REQ) begin
			n = $urandom_range(1, 5);
			repeat (n) begin
				status_in  = {$urandom, $urandom};
				status_set = 1'b1;
				m_req      = status_in;
				m_req_cnt  = m_req_cnt + 4'd1;
				@(posedge clk_sys);
				#2;
				status_set = 1'b0;
				gap = $urandom_range(1, 3);
				repeat (gap) @(posedge clk_sys);
				#2;
			end
			tx_data.delete();
			repeat (4) begin
				tx_data.push_back(16'($urandom));
			end
			send_frame(hps_pkg::CMD_STATUS_REQ);
			check_value("request tag and count", 64'(replies[0]),
				64'({8'h00, hps_pkg::STATUS_REQ_TAG, m_req_cnt}));
			for (int i = 1; i <= 4; i++) begin
				check_value("request half", 64'(replies[i]), 64'(m_req[16*(i-1) +: 16]));
			end
		end

		////////////////////
		// keyboard
		////////////////////
		// kinds are make, break, make, skipped and special sequence
		repeat (N_KBD) begin
			kind = $urandom_range(0, 4);
			kbd_bytes.delete();
			if (kind == 4) begin
				seq = specials[$urandom_range(0, 2)];
				for (int i = 3; i >= 0; i--) begin
					kbd_bytes.push_back(seq[8*i +: 8]);
				end
			end else begin
				if ($urandom_range(0, 1) != 0) begin
					kbd_bytes.push_back(8'hE0);
				end
				if (kind == 1) begin
					kbd_bytes.push_back(8'hF0);
				end
				kbd_bytes.push_back(8'($urandom_range(1, 127)));
			end
			tx_data.delete();
			foreach (kbd_bytes[i]) begin
				tx_data.push_back({8'($urandom_range(0, 254)), kbd_bytes[i]});
			end
			if (kind == 3) begin
				tx_data.insert($urandom_range(0, tx_data.size()), {8'hFF, 8'($urandom)});
			end else begin
				m_key = {~m_key[10], expected_key_code()};
			end
			send_frame(hps_pkg::CMD_KBD);
			check_regs();
		end

		////////////////////
		// file download
		////////////////////
		tx_data.delete();
		tx_data.push_back(16'($urandom_range(0, 255)));
		m_index = tx_data[0][7:0];
		send_frame(hps_pkg::CMD_FILE_INDEX);
		check_regs();
		tx_data.delete();
		tx_data.push_back(16'h0001);
		m_download = 1'b1;
		send_frame(hps_pkg::CMD_FILE_TX);
		check_regs();
		tx_data.delete();
		repeat (N_DAT) begin
			tx_data.push_back(16'($urandom));
		end
		dat_words = tx_data;
		send_frame(hps_pkg::CMD_FILE_TX_DAT);
		check_regs();
		// stop waits on host_ready so every data word has left by then
		tx_data.delete();
		tx_data.push_back(16'h0000);
		m_download = 1'b0;
		send_frame(hps_pkg::CMD_FILE_TX);
		check_regs();
		check_value("ioctl_valid after stop", 64'(ioctl_valid), 64'd0);
		check_value("download word count", 64'(sink_data.size()), 64'(N_DAT));
		for (int i = 0; i < N_DAT && i < sink_data.size(); i++) begin
			check_value("download data", 64'(sink_data[i]), 64'(dat_words[i]));
			check_value("download address", 64'(sink_addr[i]), 64'(2 * i));
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
